//--- design/cpu_consts.svh
// reset PC, word and register index widths, opcode and funct codes of the MIPS subset
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define PC_INIT     32'h0000_0000
`define WORD_W      32
`define REG_ADDR_W  5

// primary opcodes
`define OP_RTYPE    6'h00
`define OP_J        6'h02
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b
`define HALT_OP     6'h3f

// funct field, R-type only
`define FN_SLL      6'h00
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`endif

//--- design/cpu_types_pkg.sv
// data word, register index, opcode, ALU op, control and pipeline latch types
`include "cpu_consts.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0]     word_t;
  typedef logic [`REG_ADDR_W-1:0] regbits_t;
  typedef logic [5:0]             opcode_t; // also holds funct

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
  } aluop_t;

  // second ALU operand source
  typedef enum logic [1:0] {B_REG, B_IMM, B_SHAMT} alusrc_t;

  typedef struct packed {
    logic    reg_wr;
    logic    mem_to_reg;
    logic    mem_rd;
    logic    mem_wr;
    aluop_t  alu_op;
    alusrc_t alu_src;
    logic    reg_dst;   // rd when set, rt otherwise
    logic    branch;
    logic    branch_ne;
    logic    jump;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t next_pc;
  } ifid_t;

  typedef struct packed {
    logic     reg_wr;
    logic     mem_to_reg;
    logic     mem_rd;
    logic     mem_wr;
    logic     halt;
    aluop_t   alu_op;
    alusrc_t  alu_src;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    logic [4:0] shamt;
    regbits_t dst;
  } idex_t;

  typedef struct packed {
    logic     reg_wr;
    logic     mem_to_reg;
    logic     mem_rd;
    logic     mem_wr;
    logic     halt;
    word_t    alu_out;
    word_t    store;
    regbits_t dst;
  } exmem_t;

  typedef struct packed {
    logic     reg_wr;
    logic     mem_to_reg;
    logic     halt;
    word_t    alu_out;
    word_t    load;
    regbits_t dst;
  } memwb_t;

  typedef struct packed {
    logic  imem_ren;
    word_t imem_addr;
  } imem_req_t;

  typedef struct packed {
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
  } dmem_req_t;

endpackage

//--- design/pipe_latch.sv
// generic pipeline stage latch with enable and flush to an all-zero bubble
`timescale 1ns/100ps

module pipe_latch #(
  parameter type T = logic [31:0]
) (
  input  logic CLK,
  input  logic nRST,
  input  logic en,
  input  logic flush,   // only acts together with en
  input  T     d,
  output T     q
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end else if (en) begin
      if (flush) begin
        q <= '0;  // bubble, no write or memory effect
      end else begin
        q <= d;
      end
    end
  end

endmodule

//--- design/control_unit.sv
// instruction decoder for the MIPS subset, builds the control struct and immediates
`timescale 1ns/100ps
`include "cpu_consts.svh"

module control_unit (
  input  cpu_types_pkg::word_t    instr,
  output cpu_types_pkg::ctrl_t    ctrl,
  output cpu_types_pkg::regbits_t rs,
  output cpu_types_pkg::regbits_t rt,
  output cpu_types_pkg::regbits_t rd,
  output cpu_types_pkg::word_t    imm_ext,
  output logic [4:0]              shamt,
  output cpu_types_pkg::word_t    jaddr
);

  cpu_types_pkg::opcode_t op;
  cpu_types_pkg::opcode_t funct;
  logic                   zero_ext;  // ORI and LUI take the raw immediate
  logic                   rtype_ok;

  assign op    = instr[31:26];
  assign funct = instr[5:0];
  assign rs    = instr[25:21];
  assign rt    = instr[20:16];
  assign rd    = instr[15:11];
  assign shamt = instr[10:6];
  assign jaddr = {4'b0000, instr[25:0], 2'b00};  // upper bits come from the PC

  assign zero_ext = (op == `OP_ORI) || (op == `OP_LUI);
  assign imm_ext  = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  always_comb begin
    ctrl     = '0;
    rtype_ok = 1'b1;
    case (op)
      `OP_RTYPE: begin
        case (funct)
          `FN_ADDU: ctrl.alu_op = cpu_types_pkg::ALU_ADD;
          `FN_SUBU: ctrl.alu_op = cpu_types_pkg::ALU_SUB;
          `FN_AND:  ctrl.alu_op = cpu_types_pkg::ALU_AND;
          `FN_OR:   ctrl.alu_op = cpu_types_pkg::ALU_OR;
          `FN_SLT:  ctrl.alu_op = cpu_types_pkg::ALU_SLT;
          `FN_SLL: begin
            ctrl.alu_op  = cpu_types_pkg::ALU_SLL;
            ctrl.alu_src = cpu_types_pkg::B_SHAMT;
          end
          default:  rtype_ok = 1'b0;
        endcase
        ctrl.reg_wr  = rtype_ok;
        ctrl.reg_dst = rtype_ok;
      end
      `OP_ADDIU, `OP_ORI, `OP_LUI: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = cpu_types_pkg::B_IMM;
        ctrl.alu_op  = (op == `OP_ADDIU) ? cpu_types_pkg::ALU_ADD :
                       (op == `OP_ORI)   ? cpu_types_pkg::ALU_OR  : cpu_types_pkg::ALU_LUI;
      end
      `OP_LW: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.mem_rd     = 1'b1;
        ctrl.alu_src    = cpu_types_pkg::B_IMM;
      end
      `OP_SW: begin
        ctrl.mem_wr  = 1'b1;
        ctrl.alu_src = cpu_types_pkg::B_IMM;
      end
      `OP_BEQ:  ctrl.branch = 1'b1;
      `OP_BNE: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = 1'b1;
      end
      `OP_J:    ctrl.jump = 1'b1;
      `HALT_OP: ctrl.halt = 1'b1;
      default:  ctrl = '0;  // unknown op becomes a bubble
    endcase
  end

endmodule

//--- design/register_file.sv
// 32 x 32 register file with constant-zero register 0 and same-cycle write-through
`timescale 1ns/100ps
`include "cpu_consts.svh"

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  input  cpu_types_pkg::word_t    wdat,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [(1 << `REG_ADDR_W)];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != '0) begin  // r0 never written
      regs[wsel] <= wdat;
    end
  end

  // writeback value bypasses the array when it targets the read port
  assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

//--- design/alu.sv
// combinational ALU for the seven subset operations with zero, negative and overflow flags
`timescale 1ns/100ps

module alu (
  input  cpu_types_pkg::aluop_t alu_op,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  result,
  output logic                  zero,
  output logic                  negative,
  output logic                  overflow
);

  always_comb begin
    overflow = 1'b0;
    case (alu_op)
      cpu_types_pkg::ALU_ADD: begin
        result   = port_a + port_b;
        overflow = (port_a[31] == port_b[31]) && (result[31] != port_a[31]);
      end
      cpu_types_pkg::ALU_SUB: begin
        result   = port_a - port_b;
        overflow = (port_a[31] != port_b[31]) && (result[31] != port_a[31]);
      end
      cpu_types_pkg::ALU_AND: result = port_a & port_b;
      cpu_types_pkg::ALU_OR:  result = port_a | port_b;
      cpu_types_pkg::ALU_SLT: result = {31'b0, $signed(port_a) < $signed(port_b)};
      cpu_types_pkg::ALU_SLL: result = port_a << port_b[4:0];  // a holds rt here
      cpu_types_pkg::ALU_LUI: result = {port_b[15:0], 16'h0000};
      default:                result = '0;
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[31];

endmodule

//--- design/hazard_unit.sv
// read-after-write stall detection and branch or jump flush of the fetch latch
`timescale 1ns/100ps

module hazard_unit (
  input  cpu_types_pkg::regbits_t rs,
  input  cpu_types_pkg::regbits_t rt,
  input  logic                    uses_rt,
  input  cpu_types_pkg::regbits_t ex_dst,
  input  cpu_types_pkg::regbits_t mem_dst,
  input  cpu_types_pkg::regbits_t wb_dst,
  input  logic                    ex_wr,
  input  logic                    mem_wr,
  input  logic                    wb_wr,
  input  logic                    branch,
  input  logic                    branch_ne,
  input  logic                    jump,
  input  logic                    regs_equal,
  output logic                    stall_id,
  output logic                    flush_ifid
);

  logic rs_live, rt_live;
  logic ex_hit, mem_hit, wb_hit;
  logic taken;

  assign rs_live = (rs != '0);
  assign rt_live = uses_rt && (rt != '0);

  assign ex_hit  = ex_wr  && ((rs_live && ex_dst  == rs) || (rt_live && ex_dst  == rt));
  assign mem_hit = mem_wr && ((rs_live && mem_dst == rs) || (rt_live && mem_dst == rt));
  assign wb_hit  = wb_wr  && ((rs_live && wb_dst  == rs) || (rt_live && wb_dst  == rt));

  // writeback is normally covered by write-through, but a branch compare
  // waits one more cycle so the bypass stays off the next-PC path
  assign stall_id = ex_hit || mem_hit || (branch && wb_hit);

  assign taken      = jump || (branch && (regs_equal ^ branch_ne));
  assign flush_ifid = taken && !stall_id;

endmodule

//--- design/datapath.sv
// pipelined core top: PC, stage muxes, pipeline latches, hazard control and memory port glue
`timescale 1ns/100ps
`include "cpu_consts.svh"

module datapath (
  input  logic                     CLK,
  input  logic                     nRST,
  output cpu_types_pkg::imem_req_t imem_req,
  input  cpu_types_pkg::word_t     imemload,
  input  logic                     ihit,
  output cpu_types_pkg::dmem_req_t dmem_req,
  input  cpu_types_pkg::word_t     dmemload,
  input  logic                     dhit,
  output logic                     halt
);

  cpu_types_pkg::word_t    pc, pc_plus4, pc_next, br_target, j_target;
  cpu_types_pkg::ifid_t    ifid_d, ifid_q;
  cpu_types_pkg::idex_t    idex_d, idex_q;
  cpu_types_pkg::exmem_t   exmem_d, exmem_q;
  cpu_types_pkg::memwb_t   memwb_d, memwb_q;
  cpu_types_pkg::ctrl_t    ctrl;
  cpu_types_pkg::regbits_t rs, rt, rd, hz_rs;
  cpu_types_pkg::word_t    imm_ext, jaddr, rdat1, rdat2, wb_dat;
  cpu_types_pkg::word_t    alu_a, alu_b, alu_out;
  logic [4:0]              shamt;
  logic                    stall_id, flush_ifid, freeze, uses_rt;
  logic                    ifid_flush, pc_en, halt_seen, halt_done;

  // fetch
  assign pc_plus4 = pc + 32'd4;
  assign ifid_d   = '{instr: imemload, next_pc: pc_plus4};
  assign imem_req = '{imem_ren: 1'b1, imem_addr: pc};

  assign freeze     = (dmem_req.dmem_ren || dmem_req.dmem_wen) && !dhit;  // data miss
  assign ifid_flush = flush_ifid || !ihit || ctrl.halt || halt_seen;
  assign pc_en      = !freeze && !stall_id && (ihit || flush_ifid) && !ctrl.halt && !halt_seen;

  assign br_target = ifid_q.next_pc + {imm_ext[29:0], 2'b00};
  assign j_target  = {ifid_q.next_pc[31:28], jaddr[27:0]};
  assign pc_next   = !flush_ifid ? pc_plus4 : ctrl.jump ? j_target : br_target;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc        <= `PC_INIT;
      halt_seen <= 1'b0;
      halt_done <= 1'b0;
    end else begin
      if (pc_en) pc <= pc_next;
      halt_seen <= halt_seen || ctrl.halt;    // fetch stays shut after HALT decodes
      halt_done <= halt_done || memwb_q.halt;
    end
  end

  // decode
  control_unit u_cu (.instr(ifid_q.instr), .ctrl, .rs, .rt, .rd, .imm_ext, .shamt, .jaddr);

  register_file u_rf (
    .CLK, .nRST, .wen(memwb_q.reg_wr), .wsel(memwb_q.dst),
    .rsel1(rs), .rsel2(rt), .wdat(wb_dat), .rdat1, .rdat2
  );

  assign uses_rt = ctrl.reg_dst || ctrl.branch || ctrl.mem_wr;
  assign hz_rs   = (ctrl.jump || ctrl.halt) ? '0 : rs;  // rs field is target bits here

  hazard_unit u_hz (
    .rs(hz_rs), .rt, .uses_rt,
    .ex_dst(idex_q.dst), .mem_dst(exmem_q.dst), .wb_dst(memwb_q.dst),
    .ex_wr(idex_q.reg_wr), .mem_wr(exmem_q.reg_wr), .wb_wr(memwb_q.reg_wr),
    .branch(ctrl.branch), .branch_ne(ctrl.branch_ne), .jump(ctrl.jump),
    .regs_equal(rdat1 == rdat2), .stall_id, .flush_ifid
  );

  assign idex_d = '{reg_wr: ctrl.reg_wr, mem_to_reg: ctrl.mem_to_reg, mem_rd: ctrl.mem_rd,
                    mem_wr: ctrl.mem_wr, halt: ctrl.halt, alu_op: ctrl.alu_op,
                    alu_src: ctrl.alu_src, rdat1: rdat1, rdat2: rdat2, imm: imm_ext,
                    shamt: shamt, dst: ctrl.reg_dst ? rd : rt};

  // execute, shifts take rt on port a
  assign alu_a = (idex_q.alu_src == cpu_types_pkg::B_SHAMT) ? idex_q.rdat2 : idex_q.rdat1;

  always_comb begin
    case (idex_q.alu_src)
      cpu_types_pkg::B_IMM:   alu_b = idex_q.imm;
      cpu_types_pkg::B_SHAMT: alu_b = {27'b0, idex_q.shamt};
      default:                alu_b = idex_q.rdat2;
    endcase
  end

  alu u_alu (
    .alu_op(idex_q.alu_op), .port_a(alu_a), .port_b(alu_b),
    .result(alu_out), .zero(), .negative(), .overflow()
  );

  assign exmem_d = '{reg_wr: idex_q.reg_wr, mem_to_reg: idex_q.mem_to_reg,
                     mem_rd: idex_q.mem_rd, mem_wr: idex_q.mem_wr, halt: idex_q.halt,
                     alu_out: alu_out, store: idex_q.rdat2, dst: idex_q.dst};

  // memory
  assign dmem_req = '{dmem_ren: exmem_q.mem_rd, dmem_wen: exmem_q.mem_wr,
                      dmem_addr: exmem_q.alu_out, dmem_store: exmem_q.store};
  assign memwb_d  = '{reg_wr: exmem_q.reg_wr, mem_to_reg: exmem_q.mem_to_reg,
                      halt: exmem_q.halt, alu_out: exmem_q.alu_out, load: dmemload,
                      dst: exmem_q.dst};

  // writeback
  assign wb_dat = memwb_q.mem_to_reg ? memwb_q.load : memwb_q.alu_out;
  assign halt   = halt_done || memwb_q.halt;

  pipe_latch #(.T(cpu_types_pkg::ifid_t)) u_ifid (
    .CLK, .nRST, .en(!freeze && !stall_id), .flush(ifid_flush), .d(ifid_d), .q(ifid_q)
  );
  pipe_latch #(.T(cpu_types_pkg::idex_t)) u_idex (
    .CLK, .nRST, .en(!freeze), .flush(stall_id), .d(idex_d), .q(idex_q)  // bubble on stall
  );
  pipe_latch #(.T(cpu_types_pkg::exmem_t)) u_exmem (
    .CLK, .nRST, .en(!freeze), .flush(1'b0), .d(exmem_d), .q(exmem_q)
  );
  pipe_latch #(.T(cpu_types_pkg::memwb_t)) u_memwb (
    .CLK, .nRST, .en(!freeze), .flush(1'b0), .d(memwb_d), .q(memwb_q)
  );

endmodule

//--- test/datapath_assertions.sv
// bound concurrent checks on the data port handshake, address alignment and the halt output
`timescale 1ns/100ps

module datapath_assertions (
  input logic                     CLK,
  input logic                     nRST,
  input cpu_types_pkg::dmem_req_t dmem_req,
  input logic                     dhit,
  input logic                     halt
);

  logic req_active;

  assign req_active = dmem_req.dmem_ren || dmem_req.dmem_wen;

  single_access: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_req.dmem_ren && dmem_req.dmem_wen))
    else $error("data port read and write strobes high together");

  // a missed request holds strobes, address and store data
  request_held: assert property (@(posedge CLK) disable iff (!nRST)
    (req_active && !dhit) |=> $stable(dmem_req))
    else $error("data request changed before dhit");

  word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
    req_active |-> (dmem_req.dmem_addr[1:0] == 2'b00))
    else $error("data address not word aligned");

  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else $error("halt fell outside reset");

endmodule

bind datapath datapath_assertions u_checks (
  .CLK(CLK), .nRST(nRST), .dmem_req(dmem_req), .dhit(dhit), .halt(halt)
);

//--- test/datapath_tb.sv
// testbench for the pipelined core with clock, reset, memory models, program table and checks
`timescale 1ns/100ps
`include "cpu_consts.svh"

module datapath_tb;

  localparam int NUM_TESTS      = 6;
  localparam int RESET_CYCLES   = 16;
  localparam int IHIT_TEST      = 4;  // fetch misses only here
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (200 + RESET_CYCLES);
  localparam cpu_types_pkg::word_t HALT_WORD = {`HALT_OP, 26'h0};

  logic                      CLK;
  logic                      nRST;
  cpu_types_pkg::imem_req_t  imem_req;
  cpu_types_pkg::word_t      imemload;
  logic                      ihit;
  cpu_types_pkg::dmem_req_t  dmem_req;
  cpu_types_pkg::word_t      dmemload;
  logic                      dhit;
  logic                      halt;

  // program table
  string                     names [NUM_TESTS];
  cpu_types_pkg::word_t      progs [NUM_TESTS][16];
  int                        prog_len [NUM_TESTS];
  cpu_types_pkg::word_t      exp_a [NUM_TESTS][8];
  cpu_types_pkg::word_t      exp_d [NUM_TESTS][8];
  int                        n_exp [NUM_TESTS];

  // memory models and observed stores
  cpu_types_pkg::word_t      imem [16];
  cpu_types_pkg::word_t      dmem [cpu_types_pkg::word_t];
  cpu_types_pkg::word_t      got_a [$];
  cpu_types_pkg::word_t      got_d [$];
  logic                      random_ihit;
  logic                      busy;
  int                        wait_left;
  integer                    seed = 32'hc165_3924;
  int                        errors;
  int                        cycles = 0;

  datapath UUT (
    .CLK, .nRST, .imem_req, .imemload, .ihit, .dmem_req, .dmemload, .dhit, .halt
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic cpu_types_pkg::word_t rtype_word(input logic [5:0] fn,
      input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
    return {`OP_RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic cpu_types_pkg::word_t itype_word(input logic [5:0] op,
      input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpu_types_pkg::word_t fetch_word(input cpu_types_pkg::word_t addr);
    if (addr[31:2] < 16) return imem[addr[5:2]];
    return '0;
  endfunction

  // fill for unwritten data words from every address bit
  function automatic cpu_types_pkg::word_t fill_word(input cpu_types_pkg::word_t a);
    return {a[15:0], a[31:16]} ^ 32'h6b1d_e0f3;
  endfunction

  task automatic add_instr(input int t, input cpu_types_pkg::word_t w);
    progs[t][prog_len[t]] = w;
    prog_len[t]++;
  endtask

  task automatic add_store(input int t, input cpu_types_pkg::word_t a,
      input cpu_types_pkg::word_t d);
    exp_a[t][n_exp[t]] = a;
    exp_d[t][n_exp[t]] = d;
    n_exp[t]++;
  endtask

  task automatic load_table();
    foreach (progs[t, i]) progs[t][i] = '0;
    foreach (prog_len[t]) prog_len[t] = 0;
    foreach (n_exp[t]) n_exp[t] = 0;
    names[0] = "alu register ops";
    add_instr(0, itype_word(`OP_ADDIU, 0, 1, 16'h0007));
    add_instr(0, itype_word(`OP_ADDIU, 0, 2, 16'hfffd));  // r2 = -3
    add_instr(0, rtype_word(`FN_ADDU, 1, 2, 3, 0));
    add_instr(0, rtype_word(`FN_SUBU, 1, 2, 4, 0));
    add_instr(0, rtype_word(`FN_AND, 1, 2, 5, 0));
    add_instr(0, rtype_word(`FN_OR, 1, 2, 6, 0));
    add_instr(0, rtype_word(`FN_SLT, 2, 1, 7, 0));        // signed -3 < 7
    add_instr(0, rtype_word(`FN_SLL, 0, 1, 8, 4));
    for (int r = 3; r <= 8; r++) begin
      add_instr(0, itype_word(`OP_SW, 0, r, 16'h0100 + 16'(4 * (r - 3))));
    end
    add_instr(0, HALT_WORD);
    add_store(0, 32'h100, 32'h0000_0004);
    add_store(0, 32'h104, 32'h0000_000a);
    add_store(0, 32'h108, 32'h0000_0005);
    add_store(0, 32'h10c, 32'hffff_ffff);
    add_store(0, 32'h110, 32'h0000_0001);
    add_store(0, 32'h114, 32'h0000_0070);

    names[1] = "immediate extension";
    add_instr(1, itype_word(`OP_ADDIU, 0, 1, 16'h8000));  // sign extended
    add_instr(1, itype_word(`OP_ORI, 0, 2, 16'h8000));    // zero extended
    add_instr(1, itype_word(`OP_LUI, 0, 3, 16'h1234));
    add_instr(1, itype_word(`OP_ORI, 3, 4, 16'habcd));
    add_instr(1, itype_word(`OP_ADDIU, 4, 5, 16'hffff));
    for (int r = 1; r <= 5; r++) begin
      add_instr(1, itype_word(`OP_SW, 0, r, 16'h0200 + 16'(4 * (r - 1))));
    end
    add_instr(1, HALT_WORD);
    add_store(1, 32'h200, 32'hffff_8000);
    add_store(1, 32'h204, 32'h0000_8000);
    add_store(1, 32'h208, 32'h1234_0000);
    add_store(1, 32'h20c, 32'h1234_abcd);
    add_store(1, 32'h210, 32'h1234_abcc);

    names[2] = "dependencies and load use";
    add_instr(2, itype_word(`OP_ADDIU, 0, 1, 16'h0005));
    add_instr(2, rtype_word(`FN_ADDU, 1, 1, 2, 0));        // 10
    add_instr(2, rtype_word(`FN_SUBU, 2, 1, 3, 0));        // 5
    add_instr(2, rtype_word(`FN_SLL, 0, 3, 4, 2));         // 20
    add_instr(2, itype_word(`OP_SW, 0, 4, 16'h0300));
    add_instr(2, itype_word(`OP_LW, 0, 5, 16'h0300));
    add_instr(2, rtype_word(`FN_ADDU, 5, 4, 6, 0));        // load use gives 40
    add_instr(2, itype_word(`OP_SW, 0, 6, 16'h0304));
    add_instr(2, itype_word(`OP_LW, 0, 7, 16'h0304));
    add_instr(2, itype_word(`OP_SW, 0, 7, 16'h0308));      // loaded value stored
    add_instr(2, itype_word(`OP_ADDIU, 0, 8, 16'h0340));
    add_instr(2, itype_word(`OP_SW, 8, 2, 16'h0004));      // fresh base register
    add_instr(2, HALT_WORD);
    add_store(2, 32'h300, 32'h0000_0014);
    add_store(2, 32'h304, 32'h0000_0028);
    add_store(2, 32'h308, 32'h0000_0028);
    add_store(2, 32'h344, 32'h0000_000a);

    names[3] = "branches and jump";
    add_instr(3, itype_word(`OP_ADDIU, 0, 1, 16'h0001));
    add_instr(3, itype_word(`OP_ADDIU, 0, 2, 16'h0001));
    add_instr(3, itype_word(`OP_BEQ, 1, 2, 16'h0002));     // taken to word 5
    add_instr(3, itype_word(`OP_SW, 0, 1, 16'h0400));
    add_instr(3, itype_word(`OP_SW, 0, 1, 16'h0404));
    add_instr(3, itype_word(`OP_BNE, 1, 2, 16'h0001));     // not taken
    add_instr(3, itype_word(`OP_SW, 0, 1, 16'h0408));
    add_instr(3, itype_word(`OP_BEQ, 1, 0, 16'h0001));     // not taken
    add_instr(3, itype_word(`OP_SW, 0, 2, 16'h040c));
    add_instr(3, itype_word(`OP_BNE, 1, 0, 16'h0001));     // taken to word 11
    add_instr(3, itype_word(`OP_SW, 0, 1, 16'h0410));
    add_instr(3, {`OP_J, 26'd13});
    add_instr(3, itype_word(`OP_SW, 0, 1, 16'h0414));
    add_instr(3, itype_word(`OP_ADDIU, 0, 3, 16'h0077));
    add_instr(3, itype_word(`OP_SW, 0, 3, 16'h0418));
    add_instr(3, HALT_WORD);
    add_store(3, 32'h408, 32'h0000_0001);
    add_store(3, 32'h40c, 32'h0000_0001);
    add_store(3, 32'h418, 32'h0000_0077);

    // same control flow program under fetch misses
    names[4] = "random ihit";
    progs[4] = progs[3];
    prog_len[4] = prog_len[3];
    exp_a[4] = exp_a[3];
    exp_d[4] = exp_d[3];
    n_exp[4] = n_exp[3];

    names[5] = "halt";
    add_instr(5, itype_word(`OP_ADDIU, 0, 1, 16'h0055));
    add_instr(5, itype_word(`OP_SW, 0, 1, 16'h0500));
    add_instr(5, HALT_WORD);
    add_instr(5, itype_word(`OP_SW, 0, 1, 16'h0504));   // must never reach memory
    add_store(5, 32'h500, 32'h0000_0055);
  endtask

  // data port answers after 0 to 3 cycles
  task automatic serve_data_port();
    if (!nRST || !(dmem_req.dmem_ren || dmem_req.dmem_wen)) begin
      dhit = 1'b0;
      busy = 1'b0;
    end else begin
      if (!busy) begin
        busy      = 1'b1;
        wait_left = $unsigned($random(seed)) % 4;
      end
      if (wait_left == 0) begin
        dhit = 1'b1;
        busy = 1'b0;
        if (dmem_req.dmem_wen) begin
          dmem[dmem_req.dmem_addr] = dmem_req.dmem_store;
          got_a.push_back(dmem_req.dmem_addr);
          got_d.push_back(dmem_req.dmem_store);
        end else begin
          dmemload = dmem.exists(dmem_req.dmem_addr) ? dmem[dmem_req.dmem_addr]
                                                     : fill_word(dmem_req.dmem_addr);
        end
      end else begin
        dhit = 1'b0;
        wait_left--;
      end
    end
  endtask

  always begin
    @(posedge CLK);
    #2;
    assert (!nRST || imem_req.imem_ren) else begin
      $display("Error at %0t: imem_ren = %b, expected 1", $time, imem_req.imem_ren);
      errors++;
    end
    imemload = fetch_word(imem_req.imem_addr);
    ihit     = !random_ihit || (($random(seed) & 3) != 0);
    serve_data_port();
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: halt did not rise within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  task automatic run_test(input int t);
    int start_errors;
    start_errors = errors;
    @(posedge CLK);
    #2;
    nRST        = 1'b0;
    imem        = progs[t];
    random_ihit = (t == IHIT_TEST);
    dmem.delete();
    got_a.delete();
    got_d.delete();
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;
    while (!halt) begin
      @(posedge CLK);
      #2;
    end
    repeat (6) begin  // drained core idles with halt held
      @(posedge CLK);
      #2;
      assert (halt) else begin
        $display("Error at %0t: halt = %b, expected 1", $time, halt);
        errors++;
      end
    end
    for (int i = 0; i < n_exp[t] && i < got_a.size(); i++) begin
      assert (got_a[i] == exp_a[t][i]) else begin
        $display("Error at %0t: dmem_addr = %h, expected %h (store %0d)",
                 $time, got_a[i], exp_a[t][i], i);
        errors++;
      end
      assert (got_d[i] == exp_d[t][i]) else begin
        $display("Error at %0t: dmem_store = %h, expected %h (store %0d)",
                 $time, got_d[i], exp_d[t][i], i);
        errors++;
      end
    end
    assert (got_a.size() == n_exp[t]) else begin
      $display("Error at %0t: store count = %0d, expected %0d", $time, got_a.size(), n_exp[t]);
      errors++;
    end
    $display("test %0d %s: %s", t + 1, names[t], (errors == start_errors) ? "pass" : "FAIL");
  endtask

  initial begin
    nRST        = 1'b0;
    ihit        = 1'b1;
    imemload    = '0;
    dhit        = 1'b0;
    dmemload    = '0;
    random_ihit = 1'b0;
    busy        = 1'b0;
    wait_left   = 0;
    errors      = 0;
    load_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d errors", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+design
design/cpu_types_pkg.sv
design/pipe_latch.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/hazard_unit.sv
design/datapath.sv
test/datapath_assertions.sv
test/datapath_tb.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_types_pkg.sv
      - design/pipe_latch.sv
      - design/control_unit.sv
      - design/register_file.sv
      - design/alu.sv
      - design/hazard_unit.sv
      - design/datapath.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/datapath_assertions.sv
      - test/datapath_tb.sv
